// File: hdl/ber_pkg.sv
package ber_pkg;

    // statistics counter width
    localparam int unsigned COUNT_W = 32;

    // PRBS63 shift register length
    localparam int unsigned PRBS_W = 63;

    localparam logic [PRBS_W-1:0] DEF_SEED = 63'd1;

    // top-level parameter defaults
    localparam int DEF_SYMBOL_BITS = 10;
    localparam int DEF_CW_SYMBOLS  = 54;
    localparam int DEF_FEC_T       = 15;
    localparam int DEF_LANES       = 4;

    // serial bit stream, tx and rx
    typedef struct packed {
        logic valid;
        logic data;
    } bit_stream_t;

    // per-bit check result
    typedef struct packed {
        logic valid;
        logic error;
    } bit_result_t;

    // per-bit pass-through plus codeword report
    typedef struct packed {
        logic               bit_valid;
        logic               bit_error;
        logic               cw_done;
        logic               uncorrectable;
        logic [COUNT_W-1:0] cw_bit_errors;
    } codeword_result_t;

    typedef struct packed {
        logic [COUNT_W-1:0] total_bits;
        logic [COUNT_W-1:0] bit_errors_pre;
        logic [COUNT_W-1:0] frames;
        logic [COUNT_W-1:0] frame_errors;
        logic [COUNT_W-1:0] bit_errors_post;
    } ber_stats_t;

endpackage

// File: hdl/prbs63_gen.sv
`timescale 1ns/1ns

module prbs63_gen #(
    parameter logic [ber_pkg::PRBS_W-1:0] PRBS_SEED = ber_pkg::DEF_SEED
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en,
    output ber_pkg::bit_stream_t tx
);
    import ber_pkg::*;

    logic [PRBS_W-1:0] sr;
    logic              sr_in;

    // x^63 + x^62 + 1 feedback
    assign sr_in = sr[62] ^ sr[61];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sr       <= PRBS_SEED;
            tx.valid <= 1'b0;
        end else begin
            tx.valid <= en;
            if (en) begin
                sr      <= {sr[PRBS_W-2:0], sr_in};
                // new bit goes out together with the shift
                tx.data <= sr_in;
            end
        end
    end

endmodule

// File: hdl/prbs63_bit_checker.sv
`timescale 1ns/1ns

module prbs63_bit_checker #(
    parameter logic [ber_pkg::PRBS_W-1:0] PRBS_SEED = ber_pkg::DEF_SEED
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  ber_pkg::bit_stream_t rx,
    output ber_pkg::bit_result_t bit_res
);
    import ber_pkg::*;

    // local copy of the transmit sequence
    logic [PRBS_W-1:0] sr;
    logic              expected;

    assign expected = sr[62] ^ sr[61];

    // assumed aligned from reset, no resync
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sr            <= PRBS_SEED;
            bit_res.valid <= 1'b0;
        end else begin
            bit_res.valid <= rx.valid;
            if (rx.valid) begin
                // advance only on received bits
                sr            <= {sr[PRBS_W-2:0], expected};
                bit_res.error <= rx.data ^ expected;
            end
        end
    end

endmodule

// File: hdl/fec_codeword_tracker.sv
`timescale 1ns/1ns

module fec_codeword_tracker #(
    parameter int SYMBOL_BITS = ber_pkg::DEF_SYMBOL_BITS,
    parameter int CW_SYMBOLS  = ber_pkg::DEF_CW_SYMBOLS,
    parameter int FEC_T       = ber_pkg::DEF_FEC_T,
    parameter int LANES       = ber_pkg::DEF_LANES
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  ber_pkg::bit_result_t      bit_res,
    output ber_pkg::codeword_result_t cw_res
);
    import ber_pkg::*;

    localparam int BIT_W  = (SYMBOL_BITS > 1) ? $clog2(SYMBOL_BITS) : 1;
    localparam int SYM_W  = $clog2(CW_SYMBOLS + 1);
    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

    // err count never exceeds CW_SYMBOLS, so clip the limit there
    localparam logic [SYM_W-1:0] FEC_T_LIM =
        (FEC_T >= CW_SYMBOLS) ? SYM_W'(CW_SYMBOLS) : SYM_W'(FEC_T);

    logic [LANE_W-1:0] lane_ptr;
    logic [BIT_W-1:0]  bit_cnt;

    // per-lane codeword state
    logic               sym_err     [LANES];
    logic [SYM_W-1:0]   sym_cnt     [LANES];
    logic [SYM_W-1:0]   err_sym_cnt [LANES];
    logic [COUNT_W-1:0] bit_err_cnt [LANES];

    // lane values with the current bit folded in
    logic               sym_err_now;
    logic [SYM_W-1:0]   err_syms_now;
    logic [COUNT_W-1:0] cw_bits_now;
    logic               last_bit;
    logic               last_sym;
    logic [LANE_W-1:0]  lane_next;

    always_comb begin
        sym_err_now  = sym_err[lane_ptr] | bit_res.error;
        err_syms_now = err_sym_cnt[lane_ptr] + SYM_W'(sym_err_now);
        cw_bits_now  = bit_err_cnt[lane_ptr] + COUNT_W'(bit_res.error);
        last_bit     = (bit_cnt == BIT_W'(SYMBOL_BITS - 1));
        last_sym     = (sym_cnt[lane_ptr] == SYM_W'(CW_SYMBOLS - 1));
        // round-robin over the interleaved codewords
        if (lane_ptr == LANE_W'(LANES - 1)) begin
            lane_next = '0;
        end else begin
            lane_next = lane_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane_ptr         <= '0;
            bit_cnt          <= '0;
            cw_res.bit_valid <= 1'b0;
            cw_res.bit_error <= 1'b0;
            cw_res.cw_done   <= 1'b0;
            for (int i = 0; i < LANES; i++) begin
                sym_err[i]     <= 1'b0;
                sym_cnt[i]     <= '0;
                err_sym_cnt[i] <= '0;
                bit_err_cnt[i] <= '0;
            end
        end else begin
            cw_res.bit_valid <= bit_res.valid;
            cw_res.bit_error <= bit_res.valid & bit_res.error;
            cw_res.cw_done   <= bit_res.valid & last_bit & last_sym;
            if (bit_res.valid) begin
                if (!last_bit) begin
                    bit_cnt               <= bit_cnt + 1'b1;
                    sym_err[lane_ptr]     <= sym_err_now;
                    bit_err_cnt[lane_ptr] <= cw_bits_now;
                end else begin
                    // symbol ends on this bit
                    bit_cnt           <= '0;
                    sym_err[lane_ptr] <= 1'b0;
                    lane_ptr          <= lane_next;
                    if (last_sym) begin
                        sym_cnt[lane_ptr]     <= '0;
                        err_sym_cnt[lane_ptr] <= '0;
                        bit_err_cnt[lane_ptr] <= '0;
                        cw_res.uncorrectable  <= (err_syms_now > FEC_T_LIM);
                        cw_res.cw_bit_errors  <= cw_bits_now;
                    end else begin
                        sym_cnt[lane_ptr]     <= sym_cnt[lane_ptr] + 1'b1;
                        err_sym_cnt[lane_ptr] <= err_syms_now;
                        bit_err_cnt[lane_ptr] <= cw_bits_now;
                    end
                end
            end
        end
    end

endmodule

// File: hdl/ber_stats.sv
`timescale 1ns/1ns

module ber_stats (
    input  logic                      clk,
    input  logic                      rstn,
    input  ber_pkg::codeword_result_t cw_res,
    output ber_pkg::ber_stats_t       stats
);
    import ber_pkg::*;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            stats <= '0;
        end else begin
            // pre-FEC counts, one per received bit
            if (cw_res.bit_valid) begin
                stats.total_bits     <= stats.total_bits + 1'b1;
                stats.bit_errors_pre <= stats.bit_errors_pre + COUNT_W'(cw_res.bit_error);
            end
            if (cw_res.cw_done) begin
                stats.frames <= stats.frames + 1'b1;
                // only codewords the decoder cannot fix leak errors
                if (cw_res.uncorrectable) begin
                    stats.frame_errors    <= stats.frame_errors + 1'b1;
                    stats.bit_errors_post <= stats.bit_errors_post + cw_res.cw_bit_errors;
                end
            end
        end
    end

endmodule

// File: hdl/ber_tester.sv
`timescale 1ns/1ns

module ber_tester #(
    parameter logic [ber_pkg::PRBS_W-1:0] PRBS_SEED = ber_pkg::DEF_SEED,
    parameter int SYMBOL_BITS = ber_pkg::DEF_SYMBOL_BITS,
    parameter int CW_SYMBOLS  = ber_pkg::DEF_CW_SYMBOLS,
    parameter int FEC_T       = ber_pkg::DEF_FEC_T,
    parameter int LANES       = ber_pkg::DEF_LANES
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 en,
    output ber_pkg::bit_stream_t tx,
    input  ber_pkg::bit_stream_t rx,
    output ber_pkg::ber_stats_t  stats
);
    import ber_pkg::*;

    bit_result_t      bit_res;
    codeword_result_t cw_res;

    // transmit pattern source
    prbs63_gen #(
        .PRBS_SEED (PRBS_SEED)
    ) u_gen (
        .clk  (clk),
        .rstn (rstn),
        .en   (en),
        .tx   (tx)
    );

    // receive side, rx -> stats in three stages
    prbs63_bit_checker #(
        .PRBS_SEED (PRBS_SEED)
    ) u_checker (
        .clk     (clk),
        .rstn    (rstn),
        .rx      (rx),
        .bit_res (bit_res)
    );

    fec_codeword_tracker #(
        .SYMBOL_BITS (SYMBOL_BITS),
        .CW_SYMBOLS  (CW_SYMBOLS),
        .FEC_T       (FEC_T),
        .LANES       (LANES)
    ) u_tracker (
        .clk     (clk),
        .rstn    (rstn),
        .bit_res (bit_res),
        .cw_res  (cw_res)
    );

    ber_stats u_stats (
        .clk    (clk),
        .rstn   (rstn),
        .cw_res (cw_res),
        .stats  (stats)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a rising edge so the DUT sees a full reset window
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// File: tests/tb_ber_tester.sv
`timescale 1ns/1ns

module tb_ber_tester;
    import ber_pkg::*;

    localparam int SYMBOL_BITS = 4;
    localparam int CW_SYMBOLS  = 4;
    localparam int FEC_T       = 1;
    localparam int LANES       = 2;
    localparam int ROUND_BITS  = SYMBOL_BITS * CW_SYMBOLS * LANES;
    localparam int ROUNDS      = 16;
    localparam int COLS        = 6;
    localparam int TOTAL_BITS  = ROUNDS * ROUND_BITS;
    localparam int MAX_CYCLES  = ROUNDS * 64 + 200;
    localparam int unsigned RAND_SEED = 32'h1252_e311;
    localparam logic [PRBS_W-1:0] TX_SEED = 63'h0f1e_2d3c_4b5a_6978;

    logic        clk;
    logic        rstn;
    logic        en = 1'b0;
    bit_stream_t rx = '0;
    bit_stream_t tx;
    ber_stats_t  stats;

    // mask and five expected totals per round
    logic [31:0] trace [ROUNDS * COLS];

    // cycles where en is held low
    logic        en_gap [MAX_CYCLES + 1];

    logic [PRBS_W-1:0] model_sr;
    logic              en_seen = 1'b0;
    logic              running = 1'b0;
    int                cyc = 0;
    int                bits_sent = 0;
    int                en_issued = 0;
    int                rounds_done = 0;
    int                rnd;
    int                pos;
    int                check_due [$];
    int                check_round [$];

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (5)
    ) u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    ber_tester #(
        .PRBS_SEED   (TX_SEED),
        .SYMBOL_BITS (SYMBOL_BITS),
        .CW_SYMBOLS  (CW_SYMBOLS),
        .FEC_T       (FEC_T),
        .LANES       (LANES)
    ) dut (
        .clk   (clk),
        .rstn  (rstn),
        .en    (en),
        .tx    (tx),
        .rx    (rx),
        .stats (stats)
    );

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_stats(input string label, input ber_stats_t exp, input ber_stats_t act);
        string              field;
        logic [COUNT_W-1:0] e_val;
        logic [COUNT_W-1:0] a_val;
        field = "";
        if (act.total_bits !== exp.total_bits) begin
            field = "total_bits";
            e_val = exp.total_bits;
            a_val = act.total_bits;
        end else if (act.bit_errors_pre !== exp.bit_errors_pre) begin
            field = "bit_errors_pre";
            e_val = exp.bit_errors_pre;
            a_val = act.bit_errors_pre;
        end else if (act.frames !== exp.frames) begin
            field = "frames";
            e_val = exp.frames;
            a_val = act.frames;
        end else if (act.frame_errors !== exp.frame_errors) begin
            field = "frame_errors";
            e_val = exp.frame_errors;
            a_val = act.frame_errors;
        end else if (act.bit_errors_post !== exp.bit_errors_post) begin
            field = "bit_errors_post";
            e_val = exp.bit_errors_post;
            a_val = act.bit_errors_post;
        end
        if (field != "") begin
            $display("ERR %0t stats.%s (%s) expected %0d actual %0d",
                     $time, field, label, e_val, a_val);
            stop_with_failure();
        end
    endtask

    task automatic check_tx(input bit_stream_t exp, input bit_stream_t act);
        if (act.valid !== exp.valid) begin
            $display("ERR %0t tx.valid expected %b actual %b", $time, exp.valid, act.valid);
            stop_with_failure();
        end else if (exp.valid && act.data !== exp.data) begin
            $display("ERR %0t tx.data expected %b actual %b", $time, exp.data, act.data);
            stop_with_failure();
        end
    endtask

    function automatic ber_stats_t expected_stats(input int idx);
        ber_stats_t s;
        s.total_bits      = trace[idx * COLS + 1];
        s.bit_errors_pre  = trace[idx * COLS + 2];
        s.frames          = trace[idx * COLS + 3];
        s.frame_errors    = trace[idx * COLS + 4];
        s.bit_errors_post = trace[idx * COLS + 5];
        return s;
    endfunction

    // loopback with error injection, plus enable with random gaps
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d rounds checked",
                     cyc, rounds_done, ROUNDS);
            stop_with_failure();
        end else if (running) begin
            en_seen = en;
            rx.valid <= tx.valid;
            rx.data  <= 1'b0;
            if (tx.valid) begin
                rnd = bits_sent / ROUND_BITS;
                pos = bits_sent % ROUND_BITS;
                rx.data   <= tx.data ^ trace[rnd * COLS][pos];
                bits_sent = bits_sent + 1;
                // stats shows this bit three cycles on
                if (pos == ROUND_BITS - 1) begin
                    check_due.push_back(cyc + 3);
                    check_round.push_back(rnd);
                end
            end
            if (en_issued < TOTAL_BITS && !en_gap[cyc]) begin
                en <= 1'b1;
                en_issued = en_issued + 1;
            end else begin
                en <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        bit_stream_t tx_exp;
        if (running) begin
            tx_exp.valid = en_seen;
            tx_exp.data  = 1'b0;
            if (en_seen) begin
                // x^63 + x^62 + 1 shifted left
                tx_exp.data = model_sr[62] ^ model_sr[61];
                model_sr    = {model_sr[PRBS_W-2:0], tx_exp.data};
            end
            check_tx(tx_exp, tx);
            if (check_due.size() > 0 && check_due[0] == cyc) begin
                rnd = check_round.pop_front();
                void'(check_due.pop_front());
                check_stats($sformatf("round %0d", rnd), expected_stats(rnd), stats);
                rounds_done = rounds_done + 1;
            end
        end
    end

    initial begin
        bit_stream_t tx_idle;
        tx_idle = '0;
        void'($urandom(RAND_SEED));
        for (int i = 0; i <= MAX_CYCLES; i++) begin
            en_gap[i] = (($urandom % 4) == 0);
        end
        $readmemh("tests/ber_trace.txt", trace);
        model_sr = TX_SEED;
        wait (rstn === 1'b1);
        @(negedge clk);
        check_tx(tx_idle, tx);
        check_stats("after reset", '0, stats);
        running = 1'b1;
        wait (rounds_done == ROUNDS);
        $display("All checks passed");
        $finish;
    end

endmodule

// File: tests/ber_trace.txt
// mask     total    pre      frames   frm_err  post      (hex, one round per line)
// mask bit 0 is sent first; counts are running totals after the round
00000000 00000020 00000000 00000002 00000000 00000000
00000000 00000040 00000000 00000004 00000000 00000000
00000001 00000060 00000001 00000006 00000000 00000000
00000030 00000080 00000003 00000008 00000000 00000000
0000F00F 000000A0 0000000B 0000000A 00000000 00000000
00000101 000000C0 0000000D 0000000C 00000001 00000002
00000000 000000E0 0000000D 0000000E 00000001 00000002
00007070 00000100 00000013 00000010 00000002 00000008
0F000F00 00000120 0000001B 00000012 00000003 00000010
11111111 00000140 00000023 00000014 00000005 00000018
80000001 00000160 00000025 00000016 00000005 00000018
00000000 00000180 00000025 00000018 00000005 00000018
000000F0 000001A0 00000029 0000001A 00000005 00000018
00F000F0 000001C0 00000031 0000001C 00000006 00000020
00000000 000001E0 00000031 0000001E 00000006 00000020
0000000C 00000200 00000033 00000020 00000006 00000020

// File: project.f
hdl/ber_pkg.sv
hdl/prbs63_gen.sv
hdl/prbs63_bit_checker.sv
hdl/fec_codeword_tracker.sv
hdl/ber_stats.sv
hdl/ber_tester.sv
tests/tb_clock.sv
tests/tb_ber_tester.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= project.f
TB_TOP     ?= tb_ber_tester
RTL_TOP    ?= ber_tester
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j $(JOBS)

.PHONY: all lint lint-rtl sim clean

all: sim

lint: lint-rtl
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

lint-rtl:
	$(VERILATOR) $(LINT_FLAGS) hdl/ber_pkg.sv hdl/prbs63_gen.sv hdl/prbs63_bit_checker.sv \
		hdl/fec_codeword_tracker.sv hdl/ber_stats.sv hdl/ber_tester.sv --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
